//--- common/mipsPkg.sv
package mipsPkg;

	typedef logic [31:0] word_t; // data word
	typedef logic [31:0] instr_t; // raw instruction
	typedef logic [4:0] regAddr_t; // register index
	typedef logic [5:0] opcode_t; // instr[31:26]
	typedef logic [5:0] funct_t; // instr[5:0] for r-type

	// opcodes, standard mips values plus the custom branches and halt
	localparam opcode_t opRType = 6'h00;
	localparam opcode_t opJ = 6'h02;
	localparam opcode_t opJal = 6'h03;
	localparam opcode_t opBeq = 6'h04;
	localparam opcode_t opBne = 6'h05;
	localparam opcode_t opAddi = 6'h08;
	localparam opcode_t opSlti = 6'h0a;
	localparam opcode_t opAndi = 6'h0c;
	localparam opcode_t opOri = 6'h0d;
	localparam opcode_t opXori = 6'h0e;
	localparam opcode_t opBlt = 6'h1c; // custom
	localparam opcode_t opBle = 6'h1d; // custom
	localparam opcode_t opBgt = 6'h1e; // custom
	localparam opcode_t opBge = 6'h1f; // custom
	localparam opcode_t opLw = 6'h23;
	localparam opcode_t opSw = 6'h2b;
	localparam opcode_t opHlt = 6'h3f; // custom

	// r-type funct codes
	localparam funct_t fnSll = 6'h00;
	localparam funct_t fnSrl = 6'h02;
	localparam funct_t fnJr = 6'h08;
	localparam funct_t fnAdd = 6'h20;
	localparam funct_t fnAddu = 6'h21;
	localparam funct_t fnSub = 6'h22;
	localparam funct_t fnSubu = 6'h23;
	localparam funct_t fnAnd = 6'h24;
	localparam funct_t fnOr = 6'h25;
	localparam funct_t fnXor = 6'h26;
	localparam funct_t fnNor = 6'h27;
	localparam funct_t fnSlt = 6'h2a;
	localparam funct_t fnSgt = 6'h2c; // custom

	typedef enum logic [3:0] {
		add = 4'd0,
		sub = 4'd1,
		andOp = 4'd2,
		orOp = 4'd3,
		xorOp = 4'd4,
		norOp = 4'd5,
		slt = 4'd6,
		sgt = 4'd7,
		sll = 4'd8,
		srl = 4'd9
	} aluOp_t;

	typedef enum logic [3:0] {
		none, beq, bne, blt, ble, bgt, bge, jump, jumpReg
	} branchKind_t;

	typedef struct packed {
		logic regDst; // write rd instead of rt
		logic memReadEn; // data memory read level
		logic memtoReg; // write back load data
		logic memWriteEn; // data memory store
		logic regWriteEn;
		logic aluSrc; // second operand is the immediate
		logic zeroExt; // immediate zero extended (logic ops)
		logic link; // jal, writes pc+1 to r31
		logic hlt;
		aluOp_t aluOp;
		branchKind_t branchKind;
	} ctrl_t;

endpackage

//--- flist.f
common/mipsPkg.sv
src/controlUnit.sv
src/regFile.sv
src/alu.sv
src/pcUnit.sv
src/mipsCore.sv
testbench/clockGen.sv
testbench/coreTb.sv

//--- run.sh
#!/bin/sh
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module coreTb \
	-f flist.f -o coreSim
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

output=$(./obj_dir/coreSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Finished with no errors"; then
	exit 0
fi
exit 1

//--- src/alu.sv
module alu (
	input mipsPkg::ctrl_t ctrl,
	input mipsPkg::word_t rsData,
	input mipsPkg::word_t rtData,
	input logic [15:0] imm,
	input logic [4:0] shamt,
	output mipsPkg::word_t result,
	output logic zero,
	output logic negative
);

	mipsPkg::word_t immExt;
	mipsPkg::word_t opB;
	mipsPkg::word_t diff;
	logic overflow;

	assign immExt = ctrl.zeroExt ? {16'h0000, imm} : {{16{imm[15]}}, imm};
	assign opB = ctrl.aluSrc ? immExt : rtData;

	// branch flags always come from rs - rt
	assign diff = rsData - rtData;
	assign overflow = (rsData[31] != rtData[31]) && (diff[31] != rsData[31]);
	assign zero = (diff == '0);
	assign negative = diff[31] ^ overflow; // signed rs < rt

	always_comb begin
		case (ctrl.aluOp)
			mipsPkg::add: result = rsData + opB;
			mipsPkg::sub: result = rsData - opB;
			mipsPkg::andOp: result = rsData & opB;
			mipsPkg::orOp: result = rsData | opB;
			mipsPkg::xorOp: result = rsData ^ opB;
			mipsPkg::norOp: result = ~(rsData | opB);
			mipsPkg::slt: begin
				result = {31'd0, $signed(rsData) < $signed(opB)};
			end
			mipsPkg::sgt: begin
				result = {31'd0, $signed(rsData) > $signed(opB)};
			end
			mipsPkg::sll: result = rtData << shamt; // shifted value is rt
			mipsPkg::srl: result = rtData >> shamt; // logical
			default: result = '0;
		endcase
	end

endmodule

//--- src/controlUnit.sv
module controlUnit (
	input mipsPkg::opcode_t opcode,
	input mipsPkg::funct_t funct,
	input logic rst,
	output mipsPkg::ctrl_t ctrl
);

	always_comb begin
		ctrl = '0; // everything off unless the opcode says otherwise
		if (rst) begin
			case (opcode)
				mipsPkg::opHlt: begin
					ctrl.hlt = 1'b1;
				end
				mipsPkg::opRType: begin
					ctrl.regDst = 1'b1; // result goes to rd
					ctrl.regWriteEn = 1'b1;
					case (funct)
						mipsPkg::fnAdd, mipsPkg::fnAddu: begin
							ctrl.aluOp = mipsPkg::add;
						end
						mipsPkg::fnSub, mipsPkg::fnSubu: begin
							ctrl.aluOp = mipsPkg::sub;
						end
						mipsPkg::fnAnd: ctrl.aluOp = mipsPkg::andOp;
						mipsPkg::fnOr: ctrl.aluOp = mipsPkg::orOp;
						mipsPkg::fnXor: ctrl.aluOp = mipsPkg::xorOp;
						mipsPkg::fnNor: ctrl.aluOp = mipsPkg::norOp;
						mipsPkg::fnSlt: ctrl.aluOp = mipsPkg::slt;
						mipsPkg::fnSgt: ctrl.aluOp = mipsPkg::sgt;
						mipsPkg::fnSll: ctrl.aluOp = mipsPkg::sll; // shifts rt by shamt
						mipsPkg::fnSrl: ctrl.aluOp = mipsPkg::srl;
						mipsPkg::fnJr: begin
							ctrl.regWriteEn = 1'b0; // jr writes nothing
							ctrl.branchKind = mipsPkg::jumpReg;
						end
						default: begin
							ctrl.regWriteEn = 1'b0; // unknown funct acts as a nop
							ctrl.regDst = 1'b0;
						end
					endcase
				end
				mipsPkg::opJ: begin
					ctrl.branchKind = mipsPkg::jump;
				end
				mipsPkg::opJal: begin
					ctrl.regWriteEn = 1'b1;
					ctrl.link = 1'b1; // dest r31, data pc+1
					ctrl.branchKind = mipsPkg::jump;
				end
				mipsPkg::opAddi: begin
					ctrl.regWriteEn = 1'b1; // to rt
					ctrl.aluSrc = 1'b1;
				end
				mipsPkg::opSlti: begin
					ctrl.regWriteEn = 1'b1;
					ctrl.aluSrc = 1'b1; // sign extended compare
					ctrl.aluOp = mipsPkg::slt;
				end
				mipsPkg::opAndi: begin
					ctrl.regWriteEn = 1'b1;
					ctrl.aluSrc = 1'b1;
					ctrl.zeroExt = 1'b1;
					ctrl.aluOp = mipsPkg::andOp;
				end
				mipsPkg::opOri: begin
					ctrl.regWriteEn = 1'b1;
					ctrl.aluSrc = 1'b1;
					ctrl.zeroExt = 1'b1;
					ctrl.aluOp = mipsPkg::orOp;
				end
				mipsPkg::opXori: begin
					ctrl.regWriteEn = 1'b1;
					ctrl.aluSrc = 1'b1;
					ctrl.zeroExt = 1'b1;
					ctrl.aluOp = mipsPkg::xorOp;
				end
				mipsPkg::opLw: begin
					ctrl.memReadEn = 1'b1;
					ctrl.memtoReg = 1'b1; // load data to rt
					ctrl.regWriteEn = 1'b1;
					ctrl.aluSrc = 1'b1; // base + offset
				end
				mipsPkg::opSw: begin
					ctrl.memWriteEn = 1'b1;
					ctrl.aluSrc = 1'b1;
				end
				mipsPkg::opBeq: begin
					ctrl.aluOp = mipsPkg::sub;
					ctrl.branchKind = mipsPkg::beq;
				end
				mipsPkg::opBne: begin
					ctrl.aluOp = mipsPkg::sub;
					ctrl.branchKind = mipsPkg::bne;
				end
				mipsPkg::opBlt: begin
					ctrl.aluOp = mipsPkg::sub;
					ctrl.branchKind = mipsPkg::blt;
				end
				mipsPkg::opBle: begin
					ctrl.aluOp = mipsPkg::sub;
					ctrl.branchKind = mipsPkg::ble;
				end
				mipsPkg::opBgt: begin
					ctrl.aluOp = mipsPkg::sub;
					ctrl.branchKind = mipsPkg::bgt;
				end
				mipsPkg::opBge: begin
					ctrl.aluOp = mipsPkg::sub;
					ctrl.branchKind = mipsPkg::bge;
				end
				default: ; // unknown opcode, nop
			endcase
		end
	end

endmodule

//--- src/mipsCore.sv
module mipsCore #(
	parameter int imemAddrWidth = 8
) (
	input logic clk,
	input logic rst,
	output logic [imemAddrWidth-1:0] instrAddr,
	input mipsPkg::instr_t instr,
	output mipsPkg::word_t dataAddr,
	output mipsPkg::word_t writeData,
	output logic memWriteEn,
	output logic memReadEn,
	input mipsPkg::word_t readData,
	output logic halted
);

	mipsPkg::ctrl_t ctrl;
	mipsPkg::word_t rsData;
	mipsPkg::word_t rtData;
	mipsPkg::word_t aluResult;
	mipsPkg::word_t pcNext1;
	mipsPkg::word_t wbData;
	mipsPkg::regAddr_t wbAddr;
	logic zero;
	logic negative;

	// instruction fields
	mipsPkg::opcode_t opcode;
	mipsPkg::funct_t funct;
	mipsPkg::regAddr_t rs, rt, rd;
	logic [4:0] shamt;
	logic [15:0] imm;
	logic [25:0] jumpIndex;

	assign opcode = instr[31:26];
	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign rd = instr[15:11];
	assign shamt = instr[10:6];
	assign funct = instr[5:0];
	assign imm = instr[15:0];
	assign jumpIndex = instr[25:0];

	controlUnit controlUnit_inst (.opcode(opcode), .funct(funct), .rst(rst), .ctrl(ctrl));

	regFile regFile_inst (
		.clk(clk), .rst(rst), .rsAddr(rs), .rtAddr(rt), .writeAddr(wbAddr),
		.writeData(wbData), .writeEn(ctrl.regWriteEn && !halted),
		.rsData(rsData), .rtData(rtData)
	);

	alu alu_inst (
		.ctrl(ctrl), .rsData(rsData), .rtData(rtData), .imm(imm), .shamt(shamt),
		.result(aluResult), .zero(zero), .negative(negative)
	);

	pcUnit #(.imemAddrWidth(imemAddrWidth)) pcUnit_inst (
		.clk(clk), .rst(rst), .ctrl(ctrl), .zero(zero), .negative(negative), .imm(imm),
		.jumpIndex(jumpIndex), .rsData(rsData), .instrAddr(instrAddr), .pcNext1(pcNext1),
		.halted(halted)
	);

	// write-back, link wins over regDst
	assign wbAddr = ctrl.link ? 5'd31 : (ctrl.regDst ? rd : rt);
	assign wbData = ctrl.memtoReg ? readData : (ctrl.link ? pcNext1 : aluResult);

	// data port
	assign dataAddr = aluResult;
	assign writeData = rtData;
	assign memWriteEn = ctrl.memWriteEn && !halted; // no stores once halted
	assign memReadEn = ctrl.memReadEn;

endmodule

//--- src/pcUnit.sv
module pcUnit #(
	parameter int imemAddrWidth = 8
) (
	input logic clk,
	input logic rst,
	input mipsPkg::ctrl_t ctrl,
	input logic zero,
	input logic negative,
	input logic [15:0] imm,
	input logic [25:0] jumpIndex,
	input mipsPkg::word_t rsData,
	output logic [imemAddrWidth-1:0] instrAddr,
	output mipsPkg::word_t pcNext1,
	output logic halted
);

	logic [imemAddrWidth-1:0] pc;
	logic [imemAddrWidth-1:0] pcPlus1;
	logic [imemAddrWidth-1:0] nextPc;
	mipsPkg::word_t branchTarget;
	logic taken;

	assign pcPlus1 = pc + 1'b1;
	assign pcNext1 = mipsPkg::word_t'(pcPlus1); // link value for jal
	assign branchTarget = pcNext1 + {{16{imm[15]}}, imm}; // word offset

	always_comb begin
		case (ctrl.branchKind)
			mipsPkg::beq: taken = zero;
			mipsPkg::bne: taken = !zero;
			mipsPkg::blt: taken = negative;
			mipsPkg::ble: taken = negative || zero;
			mipsPkg::bgt: taken = !negative && !zero;
			mipsPkg::bge: taken = !negative;
			default: taken = 1'b0;
		endcase
		if (ctrl.branchKind == mipsPkg::jump) nextPc = jumpIndex[imemAddrWidth-1:0];
		else if (ctrl.branchKind == mipsPkg::jumpReg) nextPc = rsData[imemAddrWidth-1:0];
		else if (taken) nextPc = branchTarget[imemAddrWidth-1:0];
		else nextPc = pcPlus1;
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			pc <= '0;
			halted <= 1'b0;
		end else if (ctrl.hlt || halted) begin
			halted <= 1'b1; // pc freezes on the hlt word
		end else begin
			pc <= nextPc;
		end
	end

	assign instrAddr = pc;

endmodule

//--- src/regFile.sv
module regFile (
	input logic clk,
	input logic rst,
	input mipsPkg::regAddr_t rsAddr,
	input mipsPkg::regAddr_t rtAddr,
	input mipsPkg::regAddr_t writeAddr,
	input mipsPkg::word_t writeData,
	input logic writeEn,
	output mipsPkg::word_t rsData,
	output mipsPkg::word_t rtData
);

	mipsPkg::word_t regs [32];

	always_ff @(posedge clk) begin
		if (!rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn && (writeAddr != 5'd0)) begin // r0 stays zero
			regs[writeAddr] <= writeData;
		end
	end

	// async read ports
	assign rsData = (rsAddr == 5'd0) ? '0 : regs[rsAddr];
	assign rtData = (rtAddr == 5'd0) ? '0 : regs[rtAddr];

endmodule

//--- testbench/clockGen.sv
module clockGen (
	output logic clk,
	output logic rst
);

	timeunit 1ns;
	timeprecision 1ps;

	initial clk = 1'b0;
	always #4 clk = ~clk; // 8 ns period

	initial begin
		rst = 1'b0;
		repeat (3) @(posedge clk); // 3 cycles in reset
		@(negedge clk);
		rst = 1'b1;
	end

endmodule

//--- testbench/coreTb.sv
module coreTb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int imemAddrWidth = 8;
	localparam int bodyLen = 40; // random part of each program
	localparam int numPrograms = 21; // directed plus 20 random
	localparam int progSlots = 64;

	logic clk, rstInit, tbRst, coreRst;
	logic [7:0] instrAddr;
	logic [31:0] instr, dataAddr, writeData, readData;
	logic memWriteEn, memReadEn, halted;

	logic [31:0] imem [256];
	logic [31:0] dmem [128];
	logic [31:0] mr [32]; // model registers
	logic [31:0] mdm [128]; // model data memory
	logic [7:0] mpc;
	logic modelHalted;
	logic [31:0] lcgState;
	int fillPtr, errorCount, testsRun, testsFailed;

	logic [5:0] rFunct [12] = '{6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27,
		6'h2a, 6'h2c, 6'h00, 6'h02};
	logic [5:0] immOp [5] = '{6'h08, 6'h0a, 6'h0c, 6'h0d, 6'h0e};
	logic [5:0] brOp [6] = '{6'h04, 6'h05, 6'h1c, 6'h1d, 6'h1e, 6'h1f};

	clockGen clockGen_inst (.clk(clk), .rst(rstInit));

	assign coreRst = rstInit & tbRst;

	mipsCore #(.imemAddrWidth(imemAddrWidth)) mipsCore_inst (
		.clk(clk), .rst(coreRst), .instrAddr(instrAddr), .instr(instr),
		.dataAddr(dataAddr), .writeData(writeData), .memWriteEn(memWriteEn),
		.memReadEn(memReadEn), .readData(readData), .halted(halted)
	);

	// memories answer in the same cycle
	assign instr = imem[instrAddr];
	assign readData = dmem[dataAddr[6:0]];

	always @(posedge clk) begin
		if (memWriteEn) dmem[dataAddr[6:0]] <= writeData; // store taken at the edge
	end

	function logic [31:0] lcgNext();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function int randBelow(int n);
		logic [31:0] r;
		r = lcgNext();
		return int'(r[30:8]) % n; // upper bits are the better ones
	endfunction

	function logic [4:0] pickReg();
		return 5'(1 + randBelow(15));
	endfunction

	function logic [31:0] encodeR(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
		logic [4:0] sh, logic [5:0] fn);
		return {6'h00, rs, rt, rd, sh, fn};
	endfunction

	function logic [31:0] encodeI(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
		logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function logic [31:0] encodeJ(logic [5:0] op, logic [25:0] idx);
		return {op, idx};
	endfunction

	task automatic emit(input logic [31:0] w);
		imem[fillPtr] = w;
		fillPtr++;
	endtask

	task automatic clearProgram();
		for (int i = 0; i < 256; i++) imem[i] = {6'h3f, 26'(i)}; // hlt everywhere, tagged
		fillPtr = 0;
	endtask

	// dump r1..r15 to words 100..114, then stop
	task automatic emitEpilogue();
		for (int i = 1; i < 16; i++) emit(encodeI(6'h2b, 5'd0, 5'(i), 16'(99 + i)));
		emit(32'hfc000000);
	endtask

	task automatic buildDirected();
		clearProgram();
		emit(encodeI(6'h08, 5'd0, 5'd1, 16'hfffb)); // 0 addi r1 = -5
		emit(encodeI(6'h0d, 5'd0, 5'd2, 16'h8001)); // zero extended
		emit(encodeI(6'h08, 5'd0, 5'd3, 16'h8001)); // sign extended
		emit(encodeI(6'h0c, 5'd3, 5'd4, 16'hffff));
		emit(encodeI(6'h0e, 5'd3, 5'd5, 16'hff00));
		emit(encodeI(6'h0a, 5'd1, 5'd6, 16'hfffd)); // 5 slti -5 < -3
		emit(encodeR(5'd1, 5'd2, 5'd7, 5'd0, 6'h20));
		emit(encodeR(5'd2, 5'd3, 5'd8, 5'd0, 6'h21));
		emit(encodeR(5'd2, 5'd1, 5'd9, 5'd0, 6'h22));
		emit(encodeR(5'd1, 5'd2, 5'd10, 5'd0, 6'h23));
		emit(encodeR(5'd3, 5'd2, 5'd11, 5'd0, 6'h24)); // 10
		emit(encodeR(5'd1, 5'd2, 5'd12, 5'd0, 6'h25));
		emit(encodeR(5'd1, 5'd3, 5'd13, 5'd0, 6'h26));
		emit(encodeR(5'd1, 5'd2, 5'd14, 5'd0, 6'h27));
		emit(encodeR(5'd1, 5'd2, 5'd15, 5'd0, 6'h2a)); // signed, negative rs
		emit(encodeI(6'h2b, 5'd0, 5'd6, 16'd0)); // 15 keep slti result
		emit(encodeI(6'h2b, 5'd0, 5'd7, 16'd1));
		emit(encodeR(5'd2, 5'd1, 5'd6, 5'd0, 6'h2c)); // sgt
		emit(encodeR(5'd0, 5'd1, 5'd7, 5'd4, 6'h00)); // sll by 4
		emit(encodeR(5'd0, 5'd1, 5'd8, 5'd28, 6'h02)); // srl by 28
		emit(encodeI(6'h2b, 5'd0, 5'd8, 16'd2)); // 20
		emit(encodeI(6'h23, 5'd0, 5'd8, 16'd2));
		emit(encodeI(6'h04, 5'd1, 5'd1, 16'd1)); // beq taken
		emit(encodeI(6'h08, 5'd0, 5'd9, 16'd1));
		emit(encodeI(6'h05, 5'd1, 5'd2, 16'd1)); // bne taken
		emit(encodeI(6'h08, 5'd0, 5'd9, 16'd2)); // 25
		emit(encodeI(6'h1c, 5'd1, 5'd2, 16'd1)); // blt
		emit(encodeI(6'h08, 5'd0, 5'd9, 16'd3));
		emit(encodeI(6'h1d, 5'd1, 5'd1, 16'd1)); // ble on equal
		emit(encodeI(6'h08, 5'd0, 5'd9, 16'd4));
		emit(encodeI(6'h1e, 5'd2, 5'd1, 16'd1)); // 30 bgt
		emit(encodeI(6'h08, 5'd0, 5'd9, 16'd5));
		emit(encodeI(6'h1f, 5'd1, 5'd2, 16'd1)); // bge not taken
		emit(encodeI(6'h08, 5'd0, 5'd10, 16'd6));
		emit(encodeJ(6'h03, 26'd37)); // jal, r31 = 35
		emit(encodeJ(6'h02, 26'd39)); // 35 back from jr
		emit(encodeI(6'h08, 5'd0, 5'd11, 16'd7));
		emit(encodeI(6'h08, 5'd31, 5'd12, 16'd0)); // read the link value
		emit(encodeR(5'd31, 5'd0, 5'd0, 5'd0, 6'h08)); // jr r31
		emitEpilogue(); // starts at 39
	endtask

	task automatic buildRandom();
		int kind;
		int off;
		logic [4:0] a, b, c;
		logic [15:0] im;
		clearProgram();
		for (int i = 0; i < bodyLen; i++) begin
			a = pickReg();
			b = pickReg();
			c = pickReg();
			im = 16'(lcgNext());
			kind = randBelow(27);
			off = randBelow(bodyLen - i); // forward, lands at most on the epilogue
			if (kind < 10) emit(encodeR(a, b, c, 5'd0, rFunct[kind]));
			else if (kind < 12) emit(encodeR(5'd0, b, c, im[4:0], rFunct[kind]));
			else if (kind < 17) emit(encodeI(immOp[kind - 12], a, b, im));
			else if (kind == 17) emit(encodeI(6'h23, 5'd0, b, 16'(randBelow(64))));
			else if (kind == 18) emit(encodeI(6'h2b, 5'd0, b, 16'(randBelow(64))));
			else if (kind < 25) emit(encodeI(brOp[kind - 19], a, b, 16'(off)));
			else if (kind == 25) emit(encodeJ(6'h02, 26'(i + 1 + off)));
			else emit(encodeJ(6'h03, 26'(i + 1 + off)));
		end
		emitEpilogue();
	endtask

	task automatic writeModelReg(input logic [4:0] idx, input logic [31:0] val);
		if (idx != 5'd0) mr[idx] = val;
	endtask

	// one instruction of the ISA model, returns the memory access it makes
	task automatic modelStep(output logic st, output logic ld, output logic [31:0] sAddr,
		output logic [31:0] sData);
		logic [31:0] ins, a, b, sx, zx;
		logic [5:0] op, fn;
		logic [4:0] rs, rt, rd, sh;
		logic [7:0] nxt, brTarget;
		ins = imem[mpc];
		op = ins[31:26];
		rs = ins[25:21];
		rt = ins[20:16];
		rd = ins[15:11];
		sh = ins[10:6];
		fn = ins[5:0];
		a = mr[rs];
		b = mr[rt];
		sx = {{16{ins[15]}}, ins[15:0]};
		zx = {16'h0000, ins[15:0]};
		nxt = mpc + 8'd1;
		brTarget = mpc + 8'd1 + sx[7:0];
		st = 1'b0;
		ld = 1'b0;
		sAddr = '0;
		sData = '0;
		case (op)
			6'h00: begin
				case (fn)
					6'h20, 6'h21: writeModelReg(rd, a + b);
					6'h22, 6'h23: writeModelReg(rd, a - b);
					6'h24: writeModelReg(rd, a & b);
					6'h25: writeModelReg(rd, a | b);
					6'h26: writeModelReg(rd, a ^ b);
					6'h27: writeModelReg(rd, ~(a | b));
					6'h2a: writeModelReg(rd, {31'd0, $signed(a) < $signed(b)});
					6'h2c: writeModelReg(rd, {31'd0, $signed(a) > $signed(b)});
					6'h00: writeModelReg(rd, b << sh);
					6'h02: writeModelReg(rd, b >> sh);
					6'h08: nxt = a[7:0];
					default: ;
				endcase
			end
			6'h08: writeModelReg(rt, a + sx);
			6'h0a: writeModelReg(rt, {31'd0, $signed(a) < $signed(sx)});
			6'h0c: writeModelReg(rt, a & zx);
			6'h0d: writeModelReg(rt, a | zx);
			6'h0e: writeModelReg(rt, a ^ zx);
			6'h23: begin
				ld = 1'b1;
				sAddr = a + sx;
				writeModelReg(rt, mdm[sAddr[6:0]]);
			end
			6'h2b: begin
				st = 1'b1;
				sAddr = a + sx;
				sData = b;
				mdm[sAddr[6:0]] = b;
			end
			6'h04: if (a == b) nxt = brTarget;
			6'h05: if (a != b) nxt = brTarget;
			6'h1c: if ($signed(a) < $signed(b)) nxt = brTarget;
			6'h1d: if ($signed(a) <= $signed(b)) nxt = brTarget;
			6'h1e: if ($signed(a) > $signed(b)) nxt = brTarget;
			6'h1f: if ($signed(a) >= $signed(b)) nxt = brTarget;
			6'h02: nxt = ins[7:0];
			6'h03: begin
				writeModelReg(5'd31, {24'd0, nxt}); // link is pc+1
				nxt = ins[7:0];
			end
			6'h3f: begin
				modelHalted = 1'b1;
				nxt = mpc;
			end
			default: ;
		endcase
		mpc = nxt;
	endtask

	task automatic checkValue(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (act !== exp) begin
			$display("error at %0t: %s expected %0h actual %0h", $time, name, exp, act);
			errorCount++;
		end
	endtask

	// sample point sits between the falling edge and the next rising edge
	task automatic nextSample();
		@(negedge clk);
		#2;
	endtask

	task automatic resetCore();
		@(negedge clk);
		tbRst = 1'b0;
		repeat (3) begin
			@(posedge clk);
			#2; // outputs settled after the edge
			checkValue("instrAddr", 32'd0, 32'(instrAddr));
			checkValue("halted", 32'd0, 32'(halted));
			checkValue("memWriteEn", 32'd0, 32'(memWriteEn));
		end
		@(negedge clk);
		tbRst = 1'b1;
		#2;
		checkValue("instrAddr", 32'd0, 32'(instrAddr));
		checkValue("halted", 32'd0, 32'(halted));
	endtask

	task automatic runProgram(input string name);
		int errorsBefore;
		int cycles;
		logic st;
		logic ld;
		logic [31:0] sAddr, sData, base;
		logic [7:0] hltPc;
		errorsBefore = errorCount;
		base = lcgNext();
		for (int i = 0; i < 128; i++) begin
			mdm[i] = base ^ (32'(i) * 32'h9e3779b1); // differs at every address
			dmem[i] <= mdm[i];
		end
		for (int i = 0; i < 32; i++) mr[i] = '0;
		mpc = '0;
		modelHalted = 1'b0;
		resetCore();
		cycles = 0;
		while (!modelHalted && cycles < 256) begin
			checkValue("instrAddr", 32'(mpc), 32'(instrAddr));
			checkValue("halted", 32'd0, 32'(halted));
			modelStep(st, ld, sAddr, sData);
			checkValue("memWriteEn", 32'(st), 32'(memWriteEn));
			checkValue("memReadEn", 32'(ld), 32'(memReadEn));
			if (st && memWriteEn) begin
				checkValue("dataAddr", sAddr, dataAddr);
				checkValue("writeData", sData, writeData);
			end
			if (ld && memReadEn) checkValue("dataAddr", sAddr, dataAddr); // load address
			nextSample();
			cycles++;
		end
		if (!modelHalted) begin
			$display("%s: program never reached its hlt instruction", name);
			errorCount++;
		end
		hltPc = mpc;
		checkValue("halted", 32'd1, 32'(halted));
		repeat (5) begin
			checkValue("instrAddr", 32'(hltPc), 32'(instrAddr));
			checkValue("memWriteEn", 32'd0, 32'(memWriteEn));
			nextSample();
		end
		for (int i = 1; i < 16; i++) begin
			checkValue($sformatf("dmem[%0d]", 99 + i), mr[i], dmem[99 + i]);
		end
		testsRun++;
		if (errorCount != errorsBefore) testsFailed++;
		$display("test %s: %s, %0d errors", name,
			(errorCount == errorsBefore) ? "pass" : "fail", errorCount - errorsBefore);
	endtask

	initial begin
		tbRst = 1'b0;
		errorCount = 0;
		testsRun = 0;
		testsFailed = 0;
		lcgState = 32'ha886;
		buildDirected();
		runProgram("directed");
		for (int p = 1; p <= 20; p++) begin
			buildRandom();
			runProgram($sformatf("random %0d", p));
		end
		$display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errorCount);
		if (testsFailed == 0 && errorCount == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

	// programs times slots times 2 cycles of 8 ns
	initial begin
		#(numPrograms * progSlots * 2 * 8);
		$display("watchdog timeout, the simulation ran too long");
		$display("Finished with errors");
		$finish;
	end

endmodule
